/* Makefile */
TOP = csr_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* dv/csr_tb.sv */
module csr_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    localparam int IRQ_WIDTH  = 32;
    localparam int RESP_LIMIT = 8;  // Cycles to wait for ack or err
    // Bus transfers per test, in test order
    localparam int NUM_XFERS  = 7 + 16 + 18 + 8 + 10;
    localparam int WATCHDOG_CYCLES = NUM_XFERS * 10 + 100;  // Margin covers reset and pulses

    logic                 clk_i, rst_i, stb_i, cyc_i, we_i, instret_i;
    csr_addr_t            addr_i;
    xlen_t                data_i, data_o;
    logic [IRQ_WIDTH-1:0] io_interrupts_i, io_interrupts_o;
    logic                 ack_o, err_o;

    int     errors = 0;
    int     checks = 0;
    integer seed   = 32'hd6c7;

    csr_top #(.IRQ_WIDTH(IRQ_WIDTH)) dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;  // 20 ns period
    end

    // ======================================================================
    // Checks and bus tasks
    // ======================================================================
    task automatic check_value(input xlen_t got, input xlen_t exp, input string what);
        checks++;
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("At %0t the DUT misbehaved: %s", $time, what);
            errors++;
        end
    endtask

    // One full handshake, strobe dropped after the response is sampled
    task automatic bus_cycle(input logic wr, input csr_addr_t addr, input xlen_t wdata,
                             output xlen_t rdata, output logic acked, output logic erred);
        int waited;
        waited = 0;
        @(posedge clk_i);
        stb_i  <= 1'b1;
        cyc_i  <= 1'b1;
        we_i   <= wr;
        addr_i <= addr;
        data_i <= wdata;
        do begin
            @(negedge clk_i);  // Outputs settled mid-cycle
            waited++;
        end while (!(ack_o || err_o) && waited < RESP_LIMIT);
        rdata = data_o;
        acked = ack_o;
        erred = err_o;
        if (!(acked || erred)) begin
            $display("No response from the DUT for address 0x%03h", addr);
            errors++;
        end
        @(posedge clk_i);
        stb_i <= 1'b0;
        cyc_i <= 1'b0;
        we_i  <= 1'b0;
    endtask

    task automatic bus_read(input csr_addr_t addr, output xlen_t rdata);
        logic acked, erred;
        bus_cycle(1'b0, addr, '0, rdata, acked, erred);
        check_true(acked && !erred, $sformatf("read of 0x%03h not acknowledged", addr));
    endtask

    task automatic bus_write(input csr_addr_t addr, input xlen_t wdata);
        logic  acked, erred;
        xlen_t unused_rdata;
        bus_cycle(1'b1, addr, wdata, unused_rdata, acked, erred);
        check_true(acked && !erred, $sformatf("write to 0x%03h not acknowledged", addr));
    endtask

    task automatic read_check(input csr_addr_t addr, input xlen_t exp, input string what);
        xlen_t rdata;
        bus_read(addr, rdata);
        check_value(rdata, exp, what);
    endtask

    task automatic pulse_irq(input logic [IRQ_WIDTH-1:0] lines);
        @(posedge clk_i);
        io_interrupts_i <= lines;
        @(posedge clk_i);
        io_interrupts_i <= '0;
        @(negedge clk_i);  // Latched on the edge above
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================
    task automatic test_reset_and_bus();
        xlen_t rdata;
        logic  acked, erred;
        read_check(CSR_MISA, 32'h4000_0100, "misa after reset");
        read_check(CSR_MTVEC, 32'hFFFF_FFFC, "mtvec after reset");
        read_check(CSR_MSTATUS, 32'h0, "mstatus after reset");
        read_check(CSR_MCOUNTINHIBIT, 32'hFFFF_FFFF, "mcountinhibit after reset");
        read_check(CSR_MHARTID, 32'h0, "mhartid");
        bus_cycle(1'b0, 12'h123, '0, rdata, acked, erred);  // Unmapped
        check_true(erred && !acked, "unmapped address 0x123 not answered with err only");
        // Held strobe, ack must follow it
        @(posedge clk_i);
        stb_i  <= 1'b1;
        cyc_i  <= 1'b1;
        addr_i <= CSR_MISA;
        @(negedge clk_i);
        @(negedge clk_i);
        check_true(ack_o, "no ack one cycle after acceptance");
        repeat (2) begin
            @(negedge clk_i);
            check_true(ack_o, "ack_o fell while stb_i was held");
        end
        @(posedge clk_i);
        stb_i <= 1'b0;
        cyc_i <= 1'b0;
        @(negedge clk_i);
        check_true(!ack_o, "ack_o stayed high after stb_i fell");
    endtask

    task automatic test_round_trip();
        csr_addr_t addrs[8] = '{CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE, CSR_MTVAL,
                                CSR_MTINST, CSR_MSTATUSH, CSR_MIE, CSR_MTVEC};
        xlen_t     val;
        foreach (addrs[i]) begin
            val = $random(seed);
            bus_write(addrs[i], val);
            read_check(addrs[i], val, $sformatf("round trip of 0x%03h", addrs[i]));
        end
    endtask

    task automatic test_trap_entry_exit();
        xlen_t vbase, epc;
        // Direct mode, every cause lands on the base
        bus_write(CSR_MTVEC, 32'h0000_1000);
        bus_write(CSR_MCAUSE, 32'h0000_0002);                // Illegal instruction
        read_check(CSR_ENTER_TRAP, 32'h0000_1000, "direct entry, exception");
        bus_write(CSR_MCAUSE, 32'h8000_0007);
        read_check(CSR_ENTER_TRAP, 32'h0000_1000, "direct entry, timer");
        // Vectored mode
        vbase = $random(seed);
        vbase[1:0] = 2'b00;
        bus_write(CSR_MTVEC, vbase | 32'h1);
        bus_write(CSR_MCAUSE, 32'h8000_0007);
        read_check(CSR_ENTER_TRAP, vbase + 32'h1C, "vectored entry, timer");
        bus_write(CSR_MCAUSE, 32'h8000_000B);
        read_check(CSR_ENTER_TRAP, vbase + 32'h2C, "vectored entry, external");
        bus_write(CSR_MCAUSE, 32'h0000_0005);                // Load access fault
        read_check(CSR_ENTER_TRAP, vbase, "vectored entry, exception");
        // MIE saved into MPIE and restored on exit
        bus_write(CSR_MSTATUS, 32'h0000_0008);
        read_check(CSR_ENTER_TRAP, vbase, "entry with MIE set");
        read_check(CSR_MSTATUS, 32'h0000_0080, "mstatus after entry");
        epc = $random(seed);
        bus_write(CSR_MEPC, epc);
        read_check(CSR_EXIT_TRAP, epc, "exit return address");
        read_check(CSR_MSTATUS, 32'h0000_0088, "mstatus after exit");
    endtask

    task automatic test_interrupts();
        bus_write(CSR_MSTATUS, 32'h0);
        bus_write(CSR_MIP, 32'h0);
        bus_write(CSR_MIE, 32'h0000_0800);                   // Only line 11
        bus_write(CSR_MSTATUS, 32'h0000_0008);
        pulse_irq(32'h0000_0800);
        check_value(io_interrupts_o, 32'h0000_0800, "io_interrupts_o after line 11");
        read_check(CSR_MIP, 32'h0000_0800, "mip after line 11");
        pulse_irq(32'h0000_0080);                            // Disabled line
        read_check(CSR_MIP, 32'h0000_0800, "mip after disabled line 7");
        bus_write(CSR_MSTATUS, 32'h0);
        @(negedge clk_i);
        check_value(io_interrupts_o, 32'h0, "io_interrupts_o with MIE clear");
        read_check(CSR_MIP, 32'h0000_0800, "mip with MIE clear");
    endtask

    task automatic test_counters();
        xlen_t prev, cur, hi_val;
        // Inhibited since reset, so mcycle never left zero
        read_check(CSR_MCYCLE, 32'h0, "mcycle while inhibited");
        read_check(CSR_MCYCLE, 32'h0, "mcycle still inhibited");
        bus_write(CSR_MCOUNTINHIBIT, 32'h0);
        bus_read(CSR_MCYCLE, prev);
        repeat (2) begin
            bus_read(CSR_MCYCLE, cur);
            check_true(cur > prev, $sformatf("mcycle went from %0d to %0d", prev, cur));
            prev = cur;
        end
        bus_write(CSR_MINSTRET, 32'h0);
        repeat (7) begin
            @(posedge clk_i);
            instret_i <= 1'b1;
            @(posedge clk_i);
            instret_i <= 1'b0;
        end
        read_check(CSR_MINSTRET, 32'd7, "minstret after 7 pulses");
        hi_val = $random(seed);
        bus_write(CSR_MCYCLEH, hi_val);
        read_check(CSR_MCYCLEH, hi_val, "mcycleh");
    endtask

    // ======================================================================
    // Main sequence and watchdog
    // ======================================================================
    initial begin
        rst_i           = 1'b1;
        stb_i           = 1'b0;
        cyc_i           = 1'b0;
        we_i            = 1'b0;
        instret_i       = 1'b0;
        addr_i          = '0;
        data_i          = '0;
        io_interrupts_i = '0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_true(!ack_o && !err_o, "a bus response is high after reset");
        check_value(data_o, 32'h0, "data_o after reset");
        check_value(io_interrupts_o, 32'h0, "io_interrupts_o after reset");
        test_reset_and_bus();
        test_round_trip();
        test_trap_entry_exit();
        test_interrupts();
        test_counters();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

/* hw/csr_access_ctrl.sv */
module csr_access_ctrl (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              stb_i,
    input  logic              cyc_i,
    input  logic              we_i,
    input  csr_pkg::csr_addr_t addr_i,
    input  csr_pkg::xlen_t    data_i,
    input  csr_pkg::xlen_t    trap_rdata_i,
    input  csr_pkg::xlen_t    irq_rdata_i,
    input  csr_pkg::xlen_t    cnt_rdata_i,
    output logic              ack_o,
    output logic              err_o,
    output csr_pkg::xlen_t    data_o,
    output csr_pkg::csr_req_t req_o
);
    import csr_pkg::*;

    logic     ack_q, err_q;  // Registered response flags
    logic     accept;        // New transaction on this edge
    logic     hit;           // Address maps to a register
    csr_sel_e sel;
    xlen_t    rdata;         // Merged read word of all units

    // Response drops together with the strobe
    assign ack_o  = ack_q & stb_i;
    assign err_o  = err_q & stb_i;
    assign accept = stb_i & cyc_i & ~ack_o & ~err_o;
    assign rdata  = trap_rdata_i | irq_rdata_i | cnt_rdata_i;  // Non-owners give zero

    // ======================================================================
    // Address decode
    // ======================================================================
    always_comb begin
        hit = 1'b1;
        case (addr_i)
            CSR_MISA:          sel = SEL_MISA;
            CSR_MTVEC:         sel = SEL_MTVEC;
            CSR_MSTATUS:       sel = SEL_MSTATUS;
            CSR_MSTATUSH:      sel = SEL_MSTATUSH;
            CSR_MEPC:          sel = SEL_MEPC;
            CSR_MCAUSE:        sel = SEL_MCAUSE;
            CSR_MTVAL:         sel = SEL_MTVAL;
            CSR_MTINST:        sel = SEL_MTINST;
            CSR_MSCRATCH:      sel = SEL_MSCRATCH;
            CSR_MIE:           sel = SEL_MIE;
            CSR_MIP:           sel = SEL_MIP;
            CSR_MCOUNTINHIBIT: sel = SEL_MCOUNTINHIBIT;
            CSR_MCYCLE:        sel = SEL_MCYCLE;
            CSR_MCYCLEH:       sel = SEL_MCYCLEH;
            CSR_MINSTRET:      sel = SEL_MINSTRET;
            CSR_MINSTRETH:     sel = SEL_MINSTRETH;
            CSR_ENTER_TRAP:    sel = SEL_ENTER_TRAP;
            CSR_EXIT_TRAP:     sel = SEL_EXIT_TRAP;
            CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
            CSR_MHARTID, CSR_MCONFIGPTR, CSR_MTVAL2: begin
                sel = SEL_ZERO;  // Mapped, writes ignored
            end
            default: begin
                sel = SEL_ZERO;
                hit = 1'b0;      // Unmapped, answered with err
            end
        endcase
    end

    // One-cycle request, unknown addresses never reach the units
    always_comb begin
        req_o.valid = accept & hit;
        req_o.sel   = sel;
        req_o.we    = we_i;
        req_o.wdata = data_i;
    end

    // ======================================================================
    // Response flags and read data
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q  <= 1'b0;
            err_q  <= 1'b0;
            data_o <= '0;
        end else begin
            if (ack_q) ack_q <= stb_i;  // Hold until strobe falls
            if (err_q) err_q <= stb_i;
            if (accept) begin
                ack_q  <= hit;
                err_q  <= ~hit;
                data_o <= rdata;        // Zero for unmapped addresses
            end
        end
    end

    a_resp_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_o && err_o));
    a_req_single: assert property (@(posedge clk_i) disable iff (rst_i)
        req_o.valid |=> !req_o.valid);

endmodule

/* hw/csr_counters.sv */
module csr_counters (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              instret_i,
    input  csr_pkg::csr_req_t req_i,
    output csr_pkg::xlen_t    rdata_o
);
    import csr_pkg::*;

    logic [63:0] mcycle;
    logic [63:0] minstret;
    xlen_t       mcountinhibit;  // Bit 0 cycle, bit 2 instret
    logic        wr;             // Valid bus write this cycle

    assign wr = req_i.valid & req_i.we;

    // Next value of one 64-bit counter, a half write beats the increment
    function automatic logic [63:0] cnt_next(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input xlen_t       wdata
    );
        logic [63:0] nxt;
        nxt = inc ? cur + 64'd1 : cur;
        if (wr_lo) nxt = {cur[63:32], wdata};
        if (wr_hi) nxt = {wdata, cur[31:0]};
        return nxt;
    endfunction

    // Read mux
    always_comb begin
        case (req_i.sel)
            SEL_MCOUNTINHIBIT: rdata_o = mcountinhibit;
            SEL_MCYCLE:        rdata_o = mcycle[31:0];
            SEL_MCYCLEH:       rdata_o = mcycle[63:32];
            SEL_MINSTRET:      rdata_o = minstret[31:0];
            SEL_MINSTRETH:     rdata_o = minstret[63:32];
            default:           rdata_o = '0;
        endcase
    end

    // ======================================================================
    // Counter update
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mcountinhibit <= '1;  // All counters stopped
            mcycle        <= '0;
            minstret      <= '0;
        end else begin
            if (wr && req_i.sel == SEL_MCOUNTINHIBIT) mcountinhibit <= req_i.wdata;
            mcycle <= cnt_next(mcycle, ~mcountinhibit[0],
                               wr && req_i.sel == SEL_MCYCLE,
                               wr && req_i.sel == SEL_MCYCLEH, req_i.wdata);
            minstret <= cnt_next(minstret, instret_i & ~mcountinhibit[2],
                                 wr && req_i.sel == SEL_MINSTRET,
                                 wr && req_i.sel == SEL_MINSTRETH, req_i.wdata);
        end
    end

endmodule

/* hw/csr_irq_unit.sv */
module csr_irq_unit #(
    parameter int IRQ_WIDTH = 32  // Interrupt lines, 1 to 32
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  csr_pkg::csr_req_t    req_i,
    input  logic                 mstatus_mie_i,
    input  logic [IRQ_WIDTH-1:0] io_interrupts_i,
    output csr_pkg::xlen_t       rdata_o,
    output logic [IRQ_WIDTH-1:0] io_interrupts_o
);
    import csr_pkg::*;

    logic [IRQ_WIDTH-1:0] mie_q;  // Per-line enables
    logic [IRQ_WIDTH-1:0] mip_q;  // Sticky pending bits

    // Hidden from the core while globally disabled
    assign io_interrupts_o = mstatus_mie_i ? mip_q : '0;

    // Upper bits beyond IRQ_WIDTH read as zero
    always_comb begin
        rdata_o = '0;
        case (req_i.sel)
            SEL_MIE: rdata_o[IRQ_WIDTH-1:0] = mie_q;
            SEL_MIP: rdata_o[IRQ_WIDTH-1:0] = mip_q;
            default: ;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mie_q <= '0;
            mip_q <= '0;
        end else begin
            if (req_i.valid && req_i.we && req_i.sel == SEL_MIE) begin
                mie_q <= req_i.wdata[IRQ_WIDTH-1:0];
            end
            if (req_i.valid && req_i.we && req_i.sel == SEL_MIP) begin
                mip_q <= req_i.wdata[IRQ_WIDTH-1:0];             // Bus write wins
            end else if (mstatus_mie_i) begin
                mip_q <= mip_q | (io_interrupts_i & mie_q);      // Latch enabled lines
            end
        end
    end

    a_irq_masked: assert property (@(posedge clk_i) disable iff (rst_i)
        !mstatus_mie_i |-> io_interrupts_o == '0);

endmodule

/* hw/csr_pkg.sv */
package csr_pkg;

    // ======================================================================
    // Basic types
    // ======================================================================
    typedef logic [31:0] xlen_t;      // One CSR data word
    typedef logic [11:0] csr_addr_t;  // Full 12-bit CSR address space

    // ======================================================================
    // CSR addresses
    // ======================================================================
    // Machine trap setup and handling
    localparam csr_addr_t CSR_MSTATUS       = 12'h300;
    localparam csr_addr_t CSR_MISA          = 12'h301;
    localparam csr_addr_t CSR_MIE           = 12'h304;
    localparam csr_addr_t CSR_MTVEC         = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH      = 12'h310;
    localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;
    localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
    localparam csr_addr_t CSR_MEPC          = 12'h341;
    localparam csr_addr_t CSR_MCAUSE        = 12'h342;
    localparam csr_addr_t CSR_MTVAL         = 12'h343;
    localparam csr_addr_t CSR_MIP           = 12'h344;
    localparam csr_addr_t CSR_MTINST        = 12'h34A;
    localparam csr_addr_t CSR_MTVAL2        = 12'h34B;  // Reads as zero

    // Zicntr counters, low and high halves
    localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;

    // Machine information registers, all hardwired to zero
    localparam csr_addr_t CSR_MVENDORID     = 12'hF11;
    localparam csr_addr_t CSR_MARCHID       = 12'hF12;
    localparam csr_addr_t CSR_MIMPID        = 12'hF13;
    localparam csr_addr_t CSR_MHARTID       = 12'hF14;
    localparam csr_addr_t CSR_MCONFIGPTR    = 12'hF15;

    // Core-private trap sequencing, custom space
    localparam csr_addr_t CSR_ENTER_TRAP    = 12'h7C0;
    localparam csr_addr_t CSR_EXIT_TRAP     = 12'h7C1;

    // ======================================================================
    // Trap causes, vector offsets, bit positions and reset values
    // ======================================================================
    localparam xlen_t IRQ_CODE_SOFTWARE = 32'h8000_0003;
    localparam xlen_t IRQ_CODE_TIMER    = 32'h8000_0007;
    localparam xlen_t IRQ_CODE_EXTERNAL = 32'h8000_000B;

    localparam xlen_t VEC_OFS_SOFTWARE  = 32'h0000_000C;  // 4 * 3
    localparam xlen_t VEC_OFS_TIMER     = 32'h0000_001C;  // 4 * 7
    localparam xlen_t VEC_OFS_EXTERNAL  = 32'h0000_002C;  // 4 * 11

    localparam int MSTATUS_MIE_BIT  = 3;  // Global interrupt enable
    localparam int MSTATUS_MPIE_BIT = 7;  // MIE saved on trap entry

    localparam xlen_t MISA_RESET   = 32'h4000_0100;  // MXL = 1, I bit set
    localparam xlen_t INVALID_ADDR = 32'hFFFF_FFFC;  // mtvec before software sets it

    // Decoded register select, one value per register half
    typedef enum logic [4:0] {
        SEL_ZERO, SEL_MISA, SEL_MTVEC, SEL_MSTATUS, SEL_MSTATUSH,
        SEL_MEPC, SEL_MCAUSE, SEL_MTVAL, SEL_MTINST, SEL_MSCRATCH,
        SEL_MIE, SEL_MIP, SEL_MCOUNTINHIBIT,
        SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
        SEL_ENTER_TRAP, SEL_EXIT_TRAP
    } csr_sel_e;

    // Request broadcast to the register units
    typedef struct packed {
        logic     valid;  // High only in the acceptance cycle
        csr_sel_e sel;
        logic     we;
        xlen_t    wdata;
    } csr_req_t;

endpackage

/* hw/csr_top.sv */
module csr_top #(
    parameter int IRQ_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  stb_i,
    input  logic                  cyc_i,
    input  logic                  we_i,
    input  logic                  instret_i,
    input  csr_pkg::csr_addr_t    addr_i,
    input  csr_pkg::xlen_t        data_i,
    input  logic [IRQ_WIDTH-1:0]  io_interrupts_i,
    output logic                  ack_o,
    output logic                  err_o,
    output csr_pkg::xlen_t        data_o,
    output logic [IRQ_WIDTH-1:0]  io_interrupts_o
);
    import csr_pkg::*;

    csr_req_t req;                               // Broadcast to all units
    xlen_t    trap_rdata, irq_rdata, cnt_rdata;  // ORed in access control
    logic     mstatus_mie;

    // Bus front end
    csr_access_ctrl u_access (
        .clk_i, .rst_i, .stb_i, .cyc_i, .we_i, .addr_i, .data_i,
        .trap_rdata_i (trap_rdata),
        .irq_rdata_i  (irq_rdata),
        .cnt_rdata_i  (cnt_rdata),
        .ack_o, .err_o, .data_o,
        .req_o        (req)
    );

    csr_trap_status u_trap (
        .clk_i, .rst_i,
        .req_i         (req),
        .rdata_o       (trap_rdata),
        .mstatus_mie_o (mstatus_mie)
    );

    csr_irq_unit #(.IRQ_WIDTH(IRQ_WIDTH)) u_irq (
        .clk_i, .rst_i,
        .req_i         (req),
        .mstatus_mie_i (mstatus_mie),
        .io_interrupts_i,
        .rdata_o       (irq_rdata),
        .io_interrupts_o
    );

    csr_counters u_cnt (
        .clk_i, .rst_i, .instret_i,
        .req_i   (req),
        .rdata_o (cnt_rdata)
    );

endmodule

/* hw/csr_trap_status.sv */
module csr_trap_status (
    input  logic              clk_i,
    input  logic              rst_i,
    input  csr_pkg::csr_req_t req_i,
    output csr_pkg::xlen_t    rdata_o,
    output logic              mstatus_mie_o
);
    import csr_pkg::*;

    xlen_t misa, mstatus, mstatush, mtvec, mepc;
    xlen_t mcause, mtval, mtinst, mscratch;
    xlen_t mtvec_base;    // mtvec without mode bits
    xlen_t vec_ofs;       // Vectored offset for the current cause
    xlen_t handler_addr;  // Read word of trap entry

    assign mstatus_mie_o = mstatus[MSTATUS_MIE_BIT];
    assign mtvec_base    = {mtvec[31:2], 2'b00};

    // ======================================================================
    // Trap handler address
    // ======================================================================
    always_comb begin
        case (mcause)
            IRQ_CODE_SOFTWARE: vec_ofs = VEC_OFS_SOFTWARE;
            IRQ_CODE_TIMER:    vec_ofs = VEC_OFS_TIMER;
            IRQ_CODE_EXTERNAL: vec_ofs = VEC_OFS_EXTERNAL;
            default:           vec_ofs = '0;  // Exceptions go to base
        endcase
    end

    // Mode 01 is vectored, anything else behaves as direct
    assign handler_addr = (mtvec[1:0] == 2'b01) ? mtvec_base + vec_ofs : mtvec_base;

    // Read mux, zero for selects owned elsewhere
    always_comb begin
        case (req_i.sel)
            SEL_MISA:       rdata_o = misa;
            SEL_MTVEC:      rdata_o = mtvec;
            SEL_MSTATUS:    rdata_o = mstatus;
            SEL_MSTATUSH:   rdata_o = mstatush;
            SEL_MEPC:       rdata_o = mepc;
            SEL_MCAUSE:     rdata_o = mcause;
            SEL_MTVAL:      rdata_o = mtval;
            SEL_MTINST:     rdata_o = mtinst;
            SEL_MSCRATCH:   rdata_o = mscratch;
            SEL_ENTER_TRAP: rdata_o = handler_addr;
            SEL_EXIT_TRAP:  rdata_o = mepc;      // Return address
            default:        rdata_o = '0;
        endcase
    end

    // ======================================================================
    // Register update, trap entry and exit
    // ======================================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            misa     <= MISA_RESET;
            mtvec    <= INVALID_ADDR;  // No handler installed yet
            mstatus  <= '0;            // Interrupts globally off
            mstatush <= '0;            // Little endian
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            mtinst   <= '0;
            mscratch <= '0;
        end else if (req_i.valid) begin
            case (req_i.sel)
                SEL_MISA:     if (req_i.we) misa <= req_i.wdata;
                SEL_MTVEC:    if (req_i.we) mtvec <= req_i.wdata;
                SEL_MSTATUS:  if (req_i.we) mstatus <= req_i.wdata;
                SEL_MSTATUSH: if (req_i.we) mstatush <= req_i.wdata;
                SEL_MEPC:     if (req_i.we) mepc <= req_i.wdata;
                SEL_MCAUSE:   if (req_i.we) mcause <= req_i.wdata;
                SEL_MTVAL:    if (req_i.we) mtval <= req_i.wdata;
                SEL_MTINST:   if (req_i.we) mtinst <= req_i.wdata;
                SEL_MSCRATCH: if (req_i.we) mscratch <= req_i.wdata;
                SEL_ENTER_TRAP: begin
                    // Save MIE, then mask to prevent preemption
                    mstatus[MSTATUS_MPIE_BIT] <= mstatus[MSTATUS_MIE_BIT];
                    mstatus[MSTATUS_MIE_BIT]  <= 1'b0;
                end
                SEL_EXIT_TRAP: begin
                    mstatus[MSTATUS_MIE_BIT]  <= mstatus[MSTATUS_MPIE_BIT];
                    mstatus[MSTATUS_MPIE_BIT] <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Interrupts masked right after entering a handler
    a_entry_masks: assert property (@(posedge clk_i) disable iff (rst_i)
        (req_i.valid && req_i.sel == SEL_ENTER_TRAP) |=> !mstatus_mie_o);

endmodule

/* project.f */
hw/csr_pkg.sv
hw/csr_access_ctrl.sv
hw/csr_trap_status.sv
hw/csr_irq_unit.sv
hw/csr_counters.sv
hw/csr_top.sv
dv/csr_tb.sv
